//--- gfx_pkg.sv
package gfx_pkg;

  // frame geometry
  localparam int coord_w   = 6;
  localparam int frame_dim = 64;
  localparam int addr_w    = 12;

  // arbiter master slots
  localparam int n_masters = 3;
  localparam int mst_line  = 0;
  localparam int mst_fill  = 1;
  localparam int mst_host  = 2;

  typedef logic [$clog2(n_masters)-1:0] mst_idx_t;

  // top byte always zero, then r, g, b
  typedef logic [31:0] pixel_t;

  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
  } point_t;

  typedef struct packed {
    point_t      p0;
    point_t      p1;
    logic [23:0] color;
  } draw_cmd_t;

  // master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [addr_w-1:0] adr;
    pixel_t            dat_w;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic   ack;
    pixel_t dat_r;
  } wb_rsp_t;

  // row-major, row * frame_dim + column
  function automatic logic [addr_w-1:0] pix_addr(input logic [coord_w-1:0] col,
                                                 input logic [coord_w-1:0] row);
    return {row, col};
  endfunction

  function automatic pixel_t color_word(input logic [23:0] rgb);
    return {8'h00, rgb};
  endfunction

endpackage

//--- line_engine.sv
`timescale 1ns/1ps

module line_engine (
  input  logic               clk,
  input  logic               rst,
  input  gfx_pkg::draw_cmd_t cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  output gfx_pkg::wb_req_t   wb_req,
  input  gfx_pkg::wb_rsp_t   wb_rsp
);
  import gfx_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_setup,
    st_plot,
    st_wait_ack,
    st_step
  } state_t;

  state_t    state;
  draw_cmd_t cmd_q;

  // running state, in the swapped frame for steep lines
  logic [coord_w-1:0]        x;
  logic [coord_w-1:0]        y;
  logic [coord_w-1:0]        x_end;
  logic [coord_w-1:0]        dx;
  logic [coord_w-1:0]        dy_abs;
  logic signed [coord_w+1:0] err;
  logic signed [coord_w+1:0] err_dec;
  logic                      steep;
  logic                      y_up;

  // setup math on the latched command
  logic [coord_w-1:0] adx;
  logic [coord_w-1:0] ady;
  logic               steep_c;
  logic [coord_w-1:0] px0, py0, px1, py1;
  logic               order_swap;
  logic [coord_w-1:0] sx0, sy0, sx1, sy1;
  logic               busy;

  assign adx = (cmd_q.p1.x > cmd_q.p0.x) ? cmd_q.p1.x - cmd_q.p0.x
                                         : cmd_q.p0.x - cmd_q.p1.x;
  assign ady = (cmd_q.p1.y > cmd_q.p0.y) ? cmd_q.p1.y - cmd_q.p0.y
                                         : cmd_q.p0.y - cmd_q.p1.y;
  assign steep_c = ady > adx;

  // steep lines walk along y, so trade the axes
  assign px0 = steep_c ? cmd_q.p0.y : cmd_q.p0.x;
  assign py0 = steep_c ? cmd_q.p0.x : cmd_q.p0.y;
  assign px1 = steep_c ? cmd_q.p1.y : cmd_q.p1.x;
  assign py1 = steep_c ? cmd_q.p1.x : cmd_q.p1.y;

  // always draw with increasing x
  assign order_swap = px0 > px1;
  assign sx0 = order_swap ? px1 : px0;
  assign sy0 = order_swap ? py1 : py0;
  assign sx1 = order_swap ? px0 : px1;
  assign sy1 = order_swap ? py0 : py1;

  assign err_dec = err - $signed({2'b00, dy_abs});

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:     if (cmd_valid) state <= st_setup;
        st_setup:    state <= st_plot;
        st_plot:     state <= st_wait_ack;
        st_wait_ack: if (wb_rsp.ack) state <= st_step;
        st_step:     state <= (x == x_end) ? st_idle : st_plot;
        default:     state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && cmd_valid) begin
      cmd_q <= cmd;
    end
    if (state == st_setup) begin
      steep  <= steep_c;
      x      <= sx0;
      y      <= sy0;
      x_end  <= sx1;
      dx     <= steep_c ? ady : adx;
      dy_abs <= steep_c ? adx : ady;
      y_up   <= sy1 > sy0;
      // error starts at half of dx
      err    <= $signed({2'b00, (steep_c ? ady : adx) >> 1});
    end
    if (state == st_step && x != x_end) begin
      x <= x + 1'b1;
      if (err_dec < 0) begin
        y   <= y_up ? y + 1'b1 : y - 1'b1;
        err <= err_dec + $signed({2'b00, dx});
      end else begin
        err <= err_dec;
      end
    end
  end

  assign cmd_ready = (state == st_idle);

  // one write cycle per pixel, cyc dropped in step
  assign busy = (state == st_plot) || (state == st_wait_ack);

  always_comb begin
    wb_req.cyc   = busy;
    wb_req.stb   = busy;
    wb_req.we    = 1'b1;
    wb_req.adr   = steep ? pix_addr(y, x) : pix_addr(x, y);
    wb_req.dat_w = color_word(cmd_q.color);
  end

  // x walks up to the end point and stops there
  assert property (@(posedge clk) disable iff (rst)
    (state inside {st_plot, st_wait_ack, st_step}) |-> (x <= x_end));

endmodule

//--- rect_fill_engine.sv
`timescale 1ns/1ps

module rect_fill_engine (
  input  logic               clk,
  input  logic               rst,
  input  gfx_pkg::draw_cmd_t cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  output gfx_pkg::wb_req_t   wb_req,
  input  gfx_pkg::wb_rsp_t   wb_rsp
);
  import gfx_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_plot,
    st_wait_ack,
    st_step
  } state_t;

  state_t             state;
  logic [coord_w-1:0] x;
  logic [coord_w-1:0] y;
  logic [coord_w-1:0] x_min;
  logic [coord_w-1:0] x_max;
  logic [coord_w-1:0] y_max;
  pixel_t             color;
  logic               row_done;
  logic               busy;

  assign row_done = (x == x_max);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:     if (cmd_valid) state <= st_plot;
        st_plot:     state <= st_wait_ack;
        st_wait_ack: if (wb_rsp.ack) state <= st_step;
        st_step:     state <= (row_done && y == y_max) ? st_idle : st_plot;
        default:     state <= st_idle;
      endcase
    end
  end

  // corners may come in any order
  always_ff @(posedge clk) begin
    if (state == st_idle && cmd_valid) begin
      x_min <= (cmd.p0.x < cmd.p1.x) ? cmd.p0.x : cmd.p1.x;
      x     <= (cmd.p0.x < cmd.p1.x) ? cmd.p0.x : cmd.p1.x;
      x_max <= (cmd.p0.x < cmd.p1.x) ? cmd.p1.x : cmd.p0.x;
      y     <= (cmd.p0.y < cmd.p1.y) ? cmd.p0.y : cmd.p1.y;
      y_max <= (cmd.p0.y < cmd.p1.y) ? cmd.p1.y : cmd.p0.y;
      color <= color_word(cmd.color);
    end else if (state == st_step) begin
      if (!row_done) begin
        x <= x + 1'b1;
      end else if (y != y_max) begin
        // wrap to the start of the next row
        x <= x_min;
        y <= y + 1'b1;
      end
    end
  end

  assign cmd_ready = (state == st_idle);
  assign busy      = (state == st_plot) || (state == st_wait_ack);

  always_comb begin
    wb_req.cyc   = busy;
    wb_req.stb   = busy;
    wb_req.we    = 1'b1;
    wb_req.adr   = pix_addr(x, y);
    wb_req.dat_w = color;
  end

endmodule

//--- wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  gfx_pkg::wb_req_t mst_req [gfx_pkg::n_masters],
  output gfx_pkg::wb_rsp_t mst_rsp [gfx_pkg::n_masters],
  output gfx_pkg::wb_req_t slv_req,
  input  gfx_pkg::wb_rsp_t slv_rsp
);
  import gfx_pkg::*;

  // grant keeps the last owner after release and serves as the rr pointer
  mst_idx_t grant;
  logic     grant_valid;
  mst_idx_t next_idx;
  logic     found;

  // first requester after the last owner
  always_comb begin
    int cand;
    found    = 1'b0;
    next_idx = grant;
    for (int k = 1; k <= n_masters; k++) begin
      cand = (int'(grant) + k) % n_masters;
      if (!found && mst_req[cand].cyc) begin
        found    = 1'b1;
        next_idx = mst_idx_t'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_valid <= 1'b0;
      grant       <= mst_idx_t'(n_masters - 1);
    end else if (grant_valid) begin
      // owner ends its cycle, bus goes free for one clock
      if (!mst_req[grant].cyc) grant_valid <= 1'b0;
    end else if (found) begin
      grant       <= next_idx;
      grant_valid <= 1'b1;
    end
  end

  assign slv_req = grant_valid ? mst_req[grant] : '0;

  always_comb begin
    for (int i = 0; i < n_masters; i++) begin
      mst_rsp[i].ack   = slv_rsp.ack && grant_valid && (grant == mst_idx_t'(i));
      mst_rsp[i].dat_r = slv_rsp.dat_r;
    end
  end

  // an ack only reaches the owner, and only while it holds its cycle
  for (genvar g = 0; g < n_masters; g++) begin : g_ack_chk
    assert property (@(posedge clk) disable iff (rst)
      mst_rsp[g].ack |-> (grant_valid && grant == mst_idx_t'(g) && mst_req[g].cyc));
  end

endmodule

//--- frame_mem.sv
`timescale 1ns/1ps

module frame_mem (
  input  logic             clk,
  input  logic             rst,
  input  gfx_pkg::wb_req_t wb_req,
  output gfx_pkg::wb_rsp_t wb_rsp
);
  import gfx_pkg::*;

  pixel_t mem [frame_dim * frame_dim];
  logic   ack_q;
  pixel_t rd_q;
  logic   access;

  // a strobe still up during the ack cycle is the same access
  assign access = wb_req.cyc && wb_req.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_req.we) begin
        mem[wb_req.adr] <= wb_req.dat_w;
      end
      rd_q <= mem[wb_req.adr];
    end
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = rd_q;

  assert property (@(posedge clk) disable iff (rst)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb));

endmodule

//--- raster_top.sv
`timescale 1ns/1ps

module raster_top (
  input  logic               clk,
  input  logic               rst,
  input  gfx_pkg::draw_cmd_t line_cmd,
  input  logic               line_cmd_valid,
  output logic               line_cmd_ready,
  input  gfx_pkg::draw_cmd_t fill_cmd,
  input  logic               fill_cmd_valid,
  output logic               fill_cmd_ready,
  input  gfx_pkg::wb_req_t   host_req,
  output gfx_pkg::wb_rsp_t   host_rsp
);
  import gfx_pkg::*;

  wb_req_t line_req;
  wb_req_t fill_req;
  wb_req_t mem_req;
  wb_rsp_t line_rsp;
  wb_rsp_t fill_rsp;
  wb_rsp_t mem_rsp;
  wb_req_t mst_req [n_masters];
  wb_rsp_t mst_rsp [n_masters];

  // arbiter slot order
  assign mst_req  = '{mst_line: line_req, mst_fill: fill_req, mst_host: host_req};
  assign line_rsp = mst_rsp[mst_line];
  assign fill_rsp = mst_rsp[mst_fill];
  assign host_rsp = mst_rsp[mst_host];

  line_engine i_line_engine (
    .clk       (clk),
    .rst       (rst),
    .cmd       (line_cmd),
    .cmd_valid (line_cmd_valid),
    .cmd_ready (line_cmd_ready),
    .wb_req    (line_req),
    .wb_rsp    (line_rsp)
  );

  rect_fill_engine i_rect_fill_engine (
    .clk       (clk),
    .rst       (rst),
    .cmd       (fill_cmd),
    .cmd_valid (fill_cmd_valid),
    .cmd_ready (fill_cmd_ready),
    .wb_req    (fill_req),
    .wb_rsp    (fill_rsp)
  );

  wb_arbiter i_wb_arbiter (
    .clk     (clk),
    .rst     (rst),
    .mst_req (mst_req),
    .mst_rsp (mst_rsp),
    .slv_req (mem_req),
    .slv_rsp (mem_rsp)
  );

  frame_mem i_frame_mem (
    .clk    (clk),
    .rst    (rst),
    .wb_req (mem_req),
    .wb_rsp (mem_rsp)
  );

endmodule

//--- raster_model.svh
`ifndef RASTER_MODEL_SVH
`define RASTER_MODEL_SVH

// expected frame contents
gfx_pkg::pixel_t model_frame [gfx_pkg::frame_dim * gfx_pkg::frame_dim];

function automatic void clear_expected();
  foreach (model_frame[i]) model_frame[i] = '0;
endfunction

function automatic void set_pixel(input int x, input int y, input logic [23:0] rgb);
  model_frame[y * gfx_pkg::frame_dim + x] = {8'h00, rgb};
endfunction

function automatic gfx_pkg::pixel_t expected_pixel(input int x, input int y);
  return model_frame[y * gfx_pkg::frame_dim + x];
endfunction

// bresenham walk, steep lines trade the axes
function automatic void plot_line(input gfx_pkg::draw_cmd_t c);
  int  x0, y0, x1, y1, tmp;
  int  dx, dy, err, ystep, y;
  bit  steep;
  x0 = int'(c.p0.x);
  y0 = int'(c.p0.y);
  x1 = int'(c.p1.x);
  y1 = int'(c.p1.y);
  steep = ((y1 > y0) ? y1 - y0 : y0 - y1) > ((x1 > x0) ? x1 - x0 : x0 - x1);
  if (steep) begin
    tmp = x0;
    x0  = y0;
    y0  = tmp;
    tmp = x1;
    x1  = y1;
    y1  = tmp;
  end
  if (x0 > x1) begin
    tmp = x0;
    x0  = x1;
    x1  = tmp;
    tmp = y0;
    y0  = y1;
    y1  = tmp;
  end
  dx    = x1 - x0;
  dy    = (y1 > y0) ? y1 - y0 : y0 - y1;
  err   = dx / 2;
  ystep = (y0 < y1) ? 1 : -1;
  y     = y0;
  for (int x = x0; x <= x1; x++) begin
    if (steep) set_pixel(y, x, c.color);
    else       set_pixel(x, y, c.color);
    err = err - dy;
    if (err < 0) begin
      y   = y + ystep;
      err = err + dx;
    end
  end
endfunction

// inclusive box between the two corners
function automatic void paint_rect(input gfx_pkg::draw_cmd_t c);
  int xa, xb, ya, yb;
  xa = (c.p0.x < c.p1.x) ? int'(c.p0.x) : int'(c.p1.x);
  xb = (c.p0.x < c.p1.x) ? int'(c.p1.x) : int'(c.p0.x);
  ya = (c.p0.y < c.p1.y) ? int'(c.p0.y) : int'(c.p1.y);
  yb = (c.p0.y < c.p1.y) ? int'(c.p1.y) : int'(c.p0.y);
  for (int y = ya; y <= yb; y++) begin
    for (int x = xa; x <= xb; x++) begin
      set_pixel(x, y, c.color);
    end
  end
endfunction

`endif

//--- tb_raster_top.sv
`timescale 1ns/1ps

module tb_raster_top;
  import gfx_pkg::*;

  `include "raster_model.svh"

  localparam int n_conc       = 6;
  localparam int n_stress     = 40;
  localparam int n_side_reads = 40;
  // 8 fixed lines, 5 fixed boxes, the concurrent pairs, 2 side commands, stress
  localparam int n_cmds       = 8 + 5 + 2 * n_conc + 2 + n_stress;
  localparam int limit_cycles = n_cmds * frame_dim * frame_dim * 8;

  logic      clk;
  logic      rst;
  draw_cmd_t line_cmd;
  logic      line_cmd_valid;
  logic      line_cmd_ready;
  draw_cmd_t fill_cmd;
  logic      fill_cmd_valid;
  logic      fill_cmd_ready;
  wb_req_t   host_req;
  wb_rsp_t   host_rsp;
  int        errors;

  raster_top i_raster_top (
    .clk            (clk),
    .rst            (rst),
    .line_cmd       (line_cmd),
    .line_cmd_valid (line_cmd_valid),
    .line_cmd_ready (line_cmd_ready),
    .fill_cmd       (fill_cmd),
    .fill_cmd_valid (fill_cmd_valid),
    .fill_cmd_ready (fill_cmd_ready),
    .host_req       (host_req),
    .host_rsp       (host_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic draw_cmd_t make_cmd(input int x0, input int y0, input int x1,
                                         input int y1, input logic [23:0] rgb);
    draw_cmd_t c;
    c.p0.x  = coord_w'(x0);
    c.p0.y  = coord_w'(y0);
    c.p1.x  = coord_w'(x1);
    c.p1.y  = coord_w'(y1);
    c.color = rgb;
    return c;
  endfunction

  // endpoints with x limited to a column band and y anywhere
  function automatic draw_cmd_t random_cmd(input int x_lo, input int x_hi);
    int          x0, y0, x1, y1;
    logic [23:0] rgb;
    x0  = $urandom_range(x_hi, x_lo);
    y0  = $urandom_range(frame_dim - 1, 0);
    x1  = $urandom_range(x_hi, x_lo);
    y1  = $urandom_range(frame_dim - 1, 0);
    rgb = 24'($urandom);
    return make_cmd(x0, y0, x1, y1, rgb);
  endfunction

  // single wishbone cycle on the host port, then one idle clock
  task automatic host_access(input logic write, input int x, input int y,
                             input pixel_t wdata, output pixel_t rdata);
    host_req.cyc   = 1'b1;
    host_req.stb   = 1'b1;
    host_req.we    = write;
    host_req.adr   = addr_w'(y * frame_dim + x);
    host_req.dat_w = wdata;
    do begin
      @(negedge clk);
    end while (!host_rsp.ack);
    rdata = host_rsp.dat_r;
    @(posedge clk);
    #1;
    host_req = '0;
    @(posedge clk);
    #1;
  endtask

  task automatic clear_frame();
    pixel_t unused;
    for (int a = 0; a < frame_dim * frame_dim; a++) begin
      host_access(1'b1, a % frame_dim, a / frame_dim, '0, unused);
    end
    clear_expected();
  endtask

  task automatic compare_frame(input string phase);
    pixel_t got;
    for (int a = 0; a < frame_dim * frame_dim; a++) begin
      host_access(1'b0, a % frame_dim, a / frame_dim, '0, got);
      if (got !== model_frame[a]) begin
        errors++;
        $display("FAILED host_rsp.dat_r %s at (%0d,%0d): expected %h actual %h",
                 phase, a % frame_dim, a / frame_dim, model_frame[a], got);
      end
    end
  endtask

  task automatic send_line(input draw_cmd_t c);
    line_cmd       = c;
    line_cmd_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!line_cmd_ready);
    @(posedge clk);
    #1;
    line_cmd_valid = 1'b0;
    plot_line(c);
  endtask

  task automatic send_fill(input draw_cmd_t c);
    fill_cmd       = c;
    fill_cmd_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!fill_cmd_ready);
    @(posedge clk);
    #1;
    fill_cmd_valid = 1'b0;
    paint_rect(c);
  endtask

  // wait for the chosen engines to report idle through cmd_ready
  task automatic wait_idle(input bit need_line, input bit need_fill);
    do begin
      @(negedge clk);
    end while (!((line_cmd_ready || !need_line) && (fill_cmd_ready || !need_fill)));
    @(posedge clk);
    #1;
  endtask

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("run timed out after %0d cycles, an engine or the host port stalled",
             limit_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    draw_cmd_t conc_lines [n_conc];
    draw_cmd_t conc_rects [n_conc];
    int        side_x [n_side_reads];
    int        side_y [n_side_reads];
    draw_cmd_t c;
    pixel_t    rd;
    void'($urandom(32'h32cd));
    errors         = 0;
    rst            = 1'b1;
    line_cmd       = '0;
    line_cmd_valid = 1'b0;
    fill_cmd       = '0;
    fill_cmd_valid = 1'b0;
    host_req       = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle state after reset
    @(negedge clk);
    if (line_cmd_ready !== 1'b1) begin
      errors++;
      $display("FAILED line_cmd_ready: expected %h actual %h", 1'b1, line_cmd_ready);
    end
    if (fill_cmd_ready !== 1'b1) begin
      errors++;
      $display("FAILED fill_cmd_ready: expected %h actual %h", 1'b1, fill_cmd_ready);
    end
    if (host_rsp.ack !== 1'b0) begin
      errors++;
      $display("FAILED host_rsp.ack: expected %h actual %h", 1'b0, host_rsp.ack);
    end
    @(posedge clk);
    #1;
    host_access(1'b1, 9, 17, 32'h00a1b2c3, rd);
    host_access(1'b0, 9, 17, '0, rd);
    if (rd !== 32'h00a1b2c3) begin
      errors++;
      $display("FAILED host_rsp.dat_r: expected %h actual %h", 32'h00a1b2c3, rd);
    end
    clear_frame();

    // fixed lines
    send_line(make_cmd(2, 5, 40, 5, 24'hff0000));
    send_line(make_cmd(10, 3, 10, 50, 24'h00ff00));
    send_line(make_cmd(0, 0, 30, 30, 24'h0000ff));
    send_line(make_cmd(20, 10, 26, 60, 24'h123456));
    send_line(make_cmd(5, 60, 60, 50, 24'habcdef));
    send_line(make_cmd(55, 40, 12, 20, 24'h7f7f00));
    send_line(make_cmd(50, 63, 45, 2, 24'h00c0de));
    send_line(make_cmd(33, 33, 33, 33, 24'hffffff));
    wait_idle(1'b1, 1'b1);
    compare_frame("lines");

    // fixed boxes with corners in both orders
    send_fill(make_cmd(40, 10, 50, 20, 24'h204060));
    send_fill(make_cmd(30, 45, 20, 35, 24'h8899aa));
    send_fill(make_cmd(7, 7, 7, 7, 24'h010203));
    send_fill(make_cmd(63, 62, 0, 62, 24'hfedcba));
    send_fill(make_cmd(5, 55, 15, 50, 24'h336699));
    wait_idle(1'b1, 1'b1);
    compare_frame("boxes");

    // both engines at once on disjoint column bands
    for (int i = 0; i < n_conc; i++) begin
      conc_lines[i] = random_cmd(0, 31);
      conc_rects[i] = random_cmd(32, 63);
    end
    fork
      for (int i = 0; i < n_conc; i++) send_line(conc_lines[i]);
      for (int i = 0; i < n_conc; i++) send_fill(conc_rects[i]);
    join
    wait_idle(1'b1, 1'b1);
    compare_frame("concurrent");

    // host reads of untouched columns 16..31 while both engines draw
    for (int i = 0; i < n_side_reads; i++) begin
      side_x[i] = $urandom_range(31, 16);
      side_y[i] = $urandom_range(frame_dim - 1, 0);
    end
    c = random_cmd(0, 15);
    fork
      send_fill(make_cmd(32, 0, 63, 63, 24'($urandom)));
      send_line(c);
      for (int i = 0; i < n_side_reads; i++) begin
        host_access(1'b0, side_x[i], side_y[i], '0, rd);
        if (rd !== expected_pixel(side_x[i], side_y[i])) begin
          errors++;
          $display("FAILED host_rsp.dat_r at (%0d,%0d) during drawing: expected %h actual %h",
                   side_x[i], side_y[i], expected_pixel(side_x[i], side_y[i]), rd);
        end
      end
    join
    wait_idle(1'b1, 1'b1);

    // random stress with the other engine idle before each issue
    for (int i = 0; i < n_stress; i++) begin
      c = random_cmd(0, frame_dim - 1);
      if ($urandom_range(1, 0) == 1) begin
        wait_idle(1'b0, 1'b1);
        send_line(c);
      end else begin
        wait_idle(1'b1, 1'b0);
        send_fill(c);
      end
    end
    wait_idle(1'b1, 1'b1);
    compare_frame("stress");

    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- raster_top.f
+incdir+.
gfx_pkg.sv
line_engine.sv
rect_fill_engine.sv
wb_arbiter.sv
frame_mem.sv
raster_top.sv
tb_raster_top.sv

//--- Bender.yml
package:
  name: raster_top

sources:
  - gfx_pkg.sv
  - line_engine.sv
  - rect_fill_engine.sv
  - wb_arbiter.sv
  - frame_mem.sv
  - raster_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_raster_top.sv
